//--- hw/spi_probe_pkg.sv
package spi_probe_pkg;

   // one SPI transfer, mode 0, msb first
   localparam int FRAME_BITS = 32;

   // command opcodes, carried in the top byte of a frame
   localparam logic [7:0] OP_NOP       = 8'h00;
   localparam logic [7:0] OP_INIT      = 8'h01;
   localparam logic [7:0] OP_WR_INV    = 8'h02;
   localparam logic [7:0] OP_RD_INV    = 8'h03;
   localparam logic [7:0] OP_WR_LEDS   = 8'h04;
   localparam logic [7:0] OP_RD_LEDS   = 8'h05;
   localparam logic [7:0] OP_WR_VEC    = 8'h06;
   localparam logic [7:0] OP_RD_VEC    = 8'h07;
   localparam logic [7:0] OP_RD_SAMPLE = 8'h08;

   // host vector
   localparam int VEC_LEN      = 4;
   localparam int VEC_BITS     = 24;
   localparam int VEC_IDX_BITS = $clog2(VEC_LEN);
   localparam int VEC_CNT_BITS = $clog2(VEC_LEN + 1);

   // capture buffer, 64 words of 16 samples
   localparam int SAMPLE_BITS = 16;
   localparam int SAMPLE_AW   = 6;

   // a received frame read as a command or as two halves
   typedef union packed {
      struct packed {
         logic [7:0]  opcode;
         logic [23:0] payload;
      } cmd;
      struct packed {
         logic [15:0] hi;
         logic [15:0] lo;
      } half;
   } frame_u;

endpackage

//--- hw/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 sck,
   input  logic                                 ss_n,
   input  logic                                 mosi,
   input  logic                                 tx_load,
   input  logic [spi_probe_pkg::FRAME_BITS-1:0] tx_word,
   output logic                                 miso,
   output logic                                 rx_valid,
   output logic [spi_probe_pkg::FRAME_BITS-1:0] rx_word
);
   import spi_probe_pkg::*;

   // pin synchronisers
   logic sck_meta;
   logic sck_sync;
   logic sck_d;
   logic ss_meta;
   logic ss_sync;
   logic ss_d;
   logic mosi_meta;
   logic mosi_sync;

   logic sck_rise;
   logic sck_fall;
   logic ss_rise;
   logic ss_fall;

   logic [$clog2(FRAME_BITS):0] bit_cnt;
   logic [FRAME_BITS-1:0]       rx_shift;
   logic [FRAME_BITS-1:0]       tx_hold;
   logic [FRAME_BITS-1:0]       tx_shift;

   // ss_n idles high, so its stages come out of reset high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sck_meta  <= 1'b0;
         sck_sync  <= 1'b0;
         sck_d     <= 1'b0;
         ss_meta   <= 1'b1;
         ss_sync   <= 1'b1;
         ss_d      <= 1'b1;
         mosi_meta <= 1'b0;
         mosi_sync <= 1'b0;
      end else begin
         sck_meta  <= sck;
         sck_sync  <= sck_meta;
         sck_d     <= sck_sync;
         ss_meta   <= ss_n;
         ss_sync   <= ss_meta;
         ss_d      <= ss_sync;
         mosi_meta <= mosi;
         mosi_sync <= mosi_meta;
      end
   end

   assign sck_rise = sck_sync & ~sck_d;
   assign sck_fall = ~sck_sync & sck_d;
   assign ss_rise  = ss_sync & ~ss_d;
   assign ss_fall  = ~ss_sync & ss_d;

   // edge count saturates so long frames never alias to 32
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         if (ss_fall) begin
            bit_cnt <= '0;
         end else if (!ss_sync && sck_rise && bit_cnt != '1) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         rx_valid <= ss_rise && (bit_cnt == FRAME_BITS);
      end
   end

   always_ff @(posedge clk) begin
      if (!ss_sync && sck_rise) begin
         rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_sync};
      end
      if (ss_rise) begin
         rx_word <= rx_shift;
      end
   end

   // tx_hold keeps the last reply so a frame without a new load repeats it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_hold  <= '0;
         tx_shift <= '0;
      end else begin
         if (tx_load) begin
            tx_hold <= tx_word;
         end
         if (ss_sync) begin
            // idle: msb is on miso before the host drops ss_n
            tx_shift <= tx_hold;
         end else if (sck_fall) begin
            tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
         end
      end
   end

   assign miso = tx_shift[FRAME_BITS-1];

endmodule

//--- hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  rx_valid,
   input  logic [spi_probe_pkg::FRAME_BITS-1:0]  rx_word,
   input  logic                                  capture_done,
   input  logic [spi_probe_pkg::SAMPLE_BITS-1:0] rd_data,
   output logic                                  tx_load,
   output logic [spi_probe_pkg::FRAME_BITS-1:0]  tx_word,
   output logic [15:0]                           leds,
   output logic                                  arm,
   output logic [spi_probe_pkg::SAMPLE_AW-1:0]   rd_addr
);
   import spi_probe_pkg::*;

   frame_u frame;

   logic [15:0]             inv_reg;
   logic [VEC_BITS-1:0]     vec [VEC_LEN];
   logic [VEC_IDX_BITS-1:0] vec_idx;
   logic [VEC_CNT_BITS-1:0] vec_cnt;
   logic                    vec_rd;
   logic                    vec_data;
   logic [SAMPLE_AW-1:0]    rd_ptr;

   logic [FRAME_BITS-1:0]   status;
   logic [FRAME_BITS-1:0]   reply_data;
   logic                    reply_ram;
   logic                    reply_pending;

   assign frame    = rx_word;
   assign status   = {15'b0, capture_done, 16'b0};
   // frames still owed to a vector transfer bypass the opcode decode
   assign vec_data = (vec_cnt != '0);
   assign rd_addr  = rd_ptr;

   // stage 1 decode, stage 2 loads the reply
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         leds          <= '0;
         rd_ptr        <= '0;
         vec_idx       <= '0;
         vec_cnt       <= '0;
         vec_rd        <= 1'b0;
         arm           <= 1'b0;
         reply_ram     <= 1'b0;
         reply_pending <= 1'b0;
         tx_load       <= 1'b0;
      end else begin
         arm           <= 1'b0;
         reply_pending <= rx_valid;
         tx_load       <= reply_pending;
         if (rx_valid) begin
            reply_ram <= 1'b0;
            if (vec_data) begin
               vec_cnt <= vec_cnt - 1'b1;
               vec_idx <= vec_idx + 1'b1;
            end else begin
               case (frame.cmd.opcode)
                  OP_INIT: begin
                     leds    <= '0;
                     rd_ptr  <= '0;
                     vec_idx <= '0;
                     arm     <= 1'b1;
                  end
                  OP_WR_LEDS: begin
                     leds <= frame.half.lo;
                  end
                  OP_WR_VEC: begin
                     vec_rd  <= 1'b0;
                     vec_cnt <= VEC_CNT_BITS'(VEC_LEN);
                     vec_idx <= '0;
                  end
                  OP_RD_VEC: begin
                     // entry 0 goes out as this command's reply
                     vec_rd  <= 1'b1;
                     vec_cnt <= VEC_CNT_BITS'(VEC_LEN);
                     vec_idx <= VEC_IDX_BITS'(1);
                  end
                  OP_RD_SAMPLE: begin
                     rd_ptr    <= rd_ptr + 1'b1;
                     reply_ram <= 1'b1;
                  end
                  default: begin
                  end
               endcase
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid) begin
         reply_data <= status;
         if (vec_data) begin
            if (!vec_rd) begin
               vec[vec_idx] <= frame.cmd.payload;
            end else if (vec_cnt != 1) begin
               reply_data <= {8'b0, vec[vec_idx]};
            end
         end else begin
            case (frame.cmd.opcode)
               OP_NOP: begin
                  reply_data <= status;
               end
               OP_INIT: begin
                  inv_reg <= '0;
                  for (int i = 0; i < VEC_LEN; i++) begin
                     vec[i] <= '0;
                  end
                  reply_data <= '0;
               end
               OP_WR_INV: begin
                  inv_reg <= ~frame.half.lo;
               end
               OP_RD_INV: begin
                  reply_data <= {16'b0, inv_reg};
               end
               OP_RD_LEDS: begin
                  reply_data <= {16'b0, leds};
               end
               OP_RD_VEC: begin
                  reply_data <= {8'b0, vec[0]};
               end
               default: begin
               end
            endcase
         end
      end
      // ram word arrives one cycle after the address was presented
      if (reply_pending) begin
         tx_word <= reply_ram ? {16'b0, rd_data} : reply_data;
      end
   end

endmodule

//--- hw/sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  arm,
   input  logic                                  probe,
   output logic                                  wr_en,
   output logic [spi_probe_pkg::SAMPLE_AW-1:0]   wr_addr,
   output logic [spi_probe_pkg::SAMPLE_BITS-1:0] wr_data,
   output logic                                  capture_done
);
   import spi_probe_pkg::*;

   logic [SAMPLE_BITS-1:0]         shift_reg;
   logic [SAMPLE_BITS-1:0]         next_word;
   logic [$clog2(SAMPLE_BITS)-1:0] bit_cnt;
   logic [$clog2(SAMPLE_BITS)-1:0] cur_bit;
   logic [SAMPLE_AW-1:0]           word_cnt;
   logic [SAMPLE_AW-1:0]           cur_word;
   logic                           running;
   logic                           sampling;

   // newest sample enters at the msb
   assign next_word = {probe, shift_reg[SAMPLE_BITS-1:1]};
   // arm restarts the burst, the arm cycle itself is sample 0
   assign cur_bit   = arm ? '0 : bit_cnt;
   assign cur_word  = arm ? '0 : word_cnt;
   assign sampling  = arm | running;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         running      <= 1'b0;
         bit_cnt      <= '0;
         word_cnt     <= '0;
         wr_en        <= 1'b0;
         wr_addr      <= '0;
         capture_done <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         if (sampling) begin
            {word_cnt, bit_cnt} <= {cur_word, cur_bit} + 1'b1;
            running <= !(&cur_bit && &cur_word);
            if (&cur_bit) begin
               wr_en   <= 1'b1;
               wr_addr <= cur_word;
            end
         end
         // done rises the cycle after the last word is written
         if (arm) begin
            capture_done <= 1'b0;
         end else if (wr_en && &wr_addr) begin
            capture_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sampling) begin
         shift_reg <= next_word;
         if (&cur_bit) begin
            wr_data <= next_word;
         end
      end
   end

endmodule

//--- hw/sample_ram.sv
`timescale 1ns/1ps

module sample_ram (
   input  logic                                  clk,
   input  logic                                  wr_en,
   input  logic [spi_probe_pkg::SAMPLE_AW-1:0]   wr_addr,
   input  logic [spi_probe_pkg::SAMPLE_BITS-1:0] wr_data,
   input  logic [spi_probe_pkg::SAMPLE_AW-1:0]   rd_addr,
   output logic [spi_probe_pkg::SAMPLE_BITS-1:0] rd_data
);
   import spi_probe_pkg::*;

   logic [SAMPLE_BITS-1:0] mem [2**SAMPLE_AW];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, old data on a same-address collision
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

//--- hw/spi_probe_top.sv
`timescale 1ns/1ps

module spi_probe_top (
   input  logic clk,
   input  logic rst_n,
   input  logic sck,
   input  logic ss_n,
   input  logic mosi,
   input  logic probe,
   output logic miso,
   output logic led_r,
   output logic led_g,
   output logic led_b
);
   import spi_probe_pkg::*;

   logic                   rx_valid;
   logic [FRAME_BITS-1:0]  rx_word;
   logic                   tx_load;
   logic [FRAME_BITS-1:0]  tx_word;
   logic [15:0]            leds;
   logic                   arm;
   logic                   capture_done;
   logic [SAMPLE_AW-1:0]   rd_addr;
   logic [SAMPLE_BITS-1:0] rd_data;
   logic                   wr_en;
   logic [SAMPLE_AW-1:0]   wr_addr;
   logic [SAMPLE_BITS-1:0] wr_data;

   spi_slave u_slave (
      .clk      (clk),
      .rst_n    (rst_n),
      .sck      (sck),
      .ss_n     (ss_n),
      .mosi     (mosi),
      .tx_load  (tx_load),
      .tx_word  (tx_word),
      .miso     (miso),
      .rx_valid (rx_valid),
      .rx_word  (rx_word)
   );

   cmd_decoder u_dec (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_valid     (rx_valid),
      .rx_word      (rx_word),
      .capture_done (capture_done),
      .rd_data      (rd_data),
      .tx_load      (tx_load),
      .tx_word      (tx_word),
      .leds         (leds),
      .arm          (arm),
      .rd_addr      (rd_addr)
   );

   sample_capture u_capture (
      .clk          (clk),
      .rst_n        (rst_n),
      .arm          (arm),
      .probe        (probe),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .capture_done (capture_done)
   );

   sample_ram u_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // rgb led is wired active low
   assign led_r = ~leds[0];
   assign led_g = ~leds[1];
   assign led_b = ~leds[2];

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk
);

   // 4 ns period
   localparam time HALF_PERIOD = 2ns;

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD);
         clk = ~clk;
      end
   end

endmodule

//--- dv/spi_probe_properties.sv
`timescale 1ns/1ps

module spi_probe_properties (
   input logic clk,
   input logic rst_n,
   input logic rx_valid,
   input logic tx_load,
   input logic wr_en,
   input logic capture_done,
   input logic led_r,
   input logic led_g,
   input logic led_b
);

   // count of failed assertions
   int fails = 0;

   // frame strobe lasts a single cycle
   property rx_valid_pulse;
      @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid;
   endproperty

   // reply is loaded two cycles after the frame strobe
   property reply_after_frame;
      @(posedge clk) disable iff (!rst_n) rx_valid |-> ##2 tx_load;
   endproperty

   property reply_has_frame;
      @(posedge clk) disable iff (!rst_n) tx_load |-> $past(rx_valid, 2);
   endproperty

   // led register clears in reset so the active-low pins go high
   property leds_off_after_reset;
      @(posedge clk) !rst_n |=> (led_r && led_g && led_b);
   endproperty

   property no_write_when_done;
      @(posedge clk) disable iff (!rst_n) !(wr_en && capture_done);
   endproperty

   assert property (rx_valid_pulse) else begin
      fails++;
      $error("rx_valid stayed high for more than one cycle");
   end
   assert property (reply_after_frame) else begin
      fails++;
      $error("tx_load missing two cycles after rx_valid");
   end
   assert property (reply_has_frame) else begin
      fails++;
      $error("tx_load without rx_valid two cycles before");
   end
   assert property (leds_off_after_reset) else begin
      fails++;
      $error("led pins not high after reset");
   end
   assert property (no_write_when_done) else begin
      fails++;
      $error("capture ram written after capture_done");
   end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
   import spi_probe_pkg::*;

   localparam int HALF_SCK    = 12;
   localparam int FRAME_GAP   = 24;
   localparam int LOAD_LIMIT  = 40;
   localparam int POLL_LIMIT  = 8;
   localparam int DRAIN_LIMIT = 50;
   // capture burst of 1024 cycles plus synchroniser and decode latency
   localparam int DONE_AFTER  = 1030;

   logic        clk;
   logic        rst_n;
   logic        sck;
   logic        ss_n;
   logic        mosi;
   logic        probe;
   logic        miso;
   logic        led_r;
   logic        led_g;
   logic        led_b;

   integer      seed;
   int unsigned cyc = 0;
   int          checks;
   int          errors;
   int          timeouts;
   int          prop_fails;
   logic [31:0] exp_q[$];
   logic [31:0] got_q[$];
   logic [31:0] cmp_got;
   logic [31:0] cmp_exp;
   logic [31:0] rnd;
   logic [31:0] rx;
   int          polls;
   int          waited;

   // reference model state
   logic [15:0]         m_inv;
   logic [15:0]         m_leds;
   logic [VEC_BITS-1:0] m_vec [VEC_LEN];
   int                  m_vec_left;
   int                  m_vec_pos;
   logic                m_vec_rd;
   logic                m_armed;
   int unsigned         m_arm_cyc;
   logic [15:0]         m_sample;

   tb_clkgen u_clkgen (
      .clk (clk)
   );

   spi_probe_top u_spi_probe_top (
      .clk   (clk),
      .rst_n (rst_n),
      .sck   (sck),
      .ss_n  (ss_n),
      .mosi  (mosi),
      .probe (probe),
      .miso  (miso),
      .led_r (led_r),
      .led_g (led_g),
      .led_b (led_b)
   );

   bind spi_probe_top spi_probe_properties u_props (.*);

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // expected reply to frame f as seen in the following frame
   function automatic logic [31:0] ref_reply(input frame_u f, input int unsigned end_cyc);
      logic        done;
      logic [31:0] status;
      logic [31:0] reply;
      done   = m_armed && (end_cyc - m_arm_cyc >= DONE_AFTER);
      status = {15'b0, done, 16'b0};
      reply  = status;
      if (m_vec_left > 0) begin
         if (!m_vec_rd) begin
            m_vec[m_vec_pos] = f.cmd.payload;
         end else if (m_vec_pos < VEC_LEN - 1) begin
            reply = {8'b0, m_vec[m_vec_pos + 1]};
         end
         m_vec_pos++;
         m_vec_left--;
      end else begin
         case (f.cmd.opcode)
            OP_INIT: begin
               m_inv  = '0;
               m_leds = '0;
               for (int i = 0; i < VEC_LEN; i++) begin
                  m_vec[i] = '0;
               end
               m_armed   = 1'b1;
               m_arm_cyc = end_cyc;
               m_sample  = {16{probe}};
               reply     = '0;
            end
            OP_WR_INV:    m_inv = ~f.half.lo;
            OP_RD_INV:    reply = {16'b0, m_inv};
            OP_WR_LEDS:   m_leds = f.half.lo;
            OP_RD_LEDS:   reply = {16'b0, m_leds};
            OP_WR_VEC,
            OP_RD_VEC: begin
               m_vec_rd   = (f.cmd.opcode == OP_RD_VEC);
               m_vec_left = VEC_LEN;
               m_vec_pos  = 0;
               if (m_vec_rd) begin
                  reply = {8'b0, m_vec[0]};
               end
            end
            OP_RD_SAMPLE: reply = {16'b0, m_sample};
            default: begin
            end
         endcase
      end
      return reply;
   endfunction

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // mode 0 spi host sending msb first
   // frames shorter than 32 bits end as aborted ones
   task automatic send_frame(input logic [31:0] data, input int nbits, output logic [31:0] word);
      int unsigned end_cyc;
      int          wait_cnt;
      word = '0;
      ss_n = 1'b0;
      for (int i = 0; i < nbits; i++) begin
         mosi = data[31-i];
         idle(HALF_SCK);
         sck  = 1'b1;
         word = {word[30:0], miso};
         idle(HALF_SCK);
         sck  = 1'b0;
      end
      idle(HALF_SCK);
      ss_n    = 1'b1;
      end_cyc = cyc;
      if (nbits == FRAME_BITS) begin
         wait_cnt = 0;
         while (!u_spi_probe_top.tx_load && wait_cnt < LOAD_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
         end
         assert (u_spi_probe_top.tx_load) else begin
            timeouts++;
            $display("timeout at %0t: no reply loaded after frame %h", $time, data);
         end
         got_q.push_back(word);
         exp_q.push_back(ref_reply(data, end_cyc));
      end
      idle(FRAME_GAP);
   endtask

   task automatic check_led_pins();
      logic [2:0] pins;
      logic [2:0] exp_pins;
      pins     = {led_b, led_g, led_r};
      exp_pins = ~m_leds[2:0];
      checks++;
      assert (pins === exp_pins) else begin
         errors++;
         $display("mismatch at %0t: led_pins got %b expected %b", $time, pins, exp_pins);
      end
   endtask

   task automatic run_capture(input logic level);
      logic [31:0] word;
      probe = level;
      send_frame({OP_INIT, 24'h0}, FRAME_BITS, word);
      polls = 0;
      word  = '0;
      while (!word[16] && polls < POLL_LIMIT) begin
         send_frame({OP_NOP, 24'h0}, FRAME_BITS, word);
         polls++;
      end
      assert (word[16]) else begin
         timeouts++;
         $display("timeout at %0t: capture never reported done", $time);
      end
      repeat (2**SAMPLE_AW) send_frame({OP_RD_SAMPLE, 24'h0}, FRAME_BITS, word);
   endtask

   // compares each received reply with the model
   always @(posedge clk) begin
      if (got_q.size() > 0 && exp_q.size() > 0) begin
         cmp_got = got_q.pop_front();
         cmp_exp = exp_q.pop_front();
         checks++;
         assert (cmp_got === cmp_exp) else begin
            errors++;
            $display("mismatch at %0t: miso_word got %h expected %h", $time, cmp_got, cmp_exp);
         end
      end
   end

   initial begin
      seed     = 32'h932d_e7fc;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      rst_n    = 1'b0;
      sck      = 1'b0;
      ss_n     = 1'b1;
      mosi     = 1'b0;
      probe    = 1'b0;
      m_inv      = '0;
      m_leds     = '0;
      m_vec_left = 0;
      m_vec_pos  = 0;
      m_vec_rd   = 1'b0;
      m_armed    = 1'b0;
      m_arm_cyc  = 0;
      m_sample   = '0;
      for (int i = 0; i < VEC_LEN; i++) begin
         m_vec[i] = '0;
      end
      // reset reply is zero
      exp_q.push_back('0);
      idle(2);
      rst_n = 1'b1;
      idle(4);
      check_led_pins();

      repeat (4) begin
         rnd = $random(seed);
         send_frame({OP_WR_INV, 8'h0, rnd[15:0]}, FRAME_BITS, rx);
         send_frame({OP_RD_INV, 24'h0}, FRAME_BITS, rx);
      end
      send_frame({OP_NOP, 24'h0}, FRAME_BITS, rx);

      repeat (4) begin
         rnd = $random(seed);
         send_frame({OP_WR_LEDS, 8'h0, rnd[15:0]}, FRAME_BITS, rx);
         check_led_pins();
         send_frame({OP_RD_LEDS, 24'h0}, FRAME_BITS, rx);
      end

      // vector written and read back before init clears it
      send_frame({OP_WR_VEC, 24'h0}, FRAME_BITS, rx);
      repeat (VEC_LEN) begin
         rnd = $random(seed);
         send_frame({8'h0, rnd[23:0]}, FRAME_BITS, rx);
      end
      send_frame({OP_RD_VEC, 24'h0}, FRAME_BITS, rx);
      repeat (VEC_LEN) begin
         rnd = $random(seed);
         send_frame(rnd, FRAME_BITS, rx);
      end
      send_frame({OP_INIT, 24'h0}, FRAME_BITS, rx);
      send_frame({OP_RD_VEC, 24'h0}, FRAME_BITS, rx);
      repeat (VEC_LEN) send_frame({OP_NOP, 24'h0}, FRAME_BITS, rx);
      send_frame({OP_NOP, 24'h0}, FRAME_BITS, rx);

      run_capture(1'b1);
      run_capture(1'b0);

      // aborted frame leaves state and pending reply alone
      send_frame({OP_WR_INV, 8'h0, 16'h1234}, FRAME_BITS, rx);
      send_frame({OP_WR_LEDS, 8'h0, 16'h0007}, 10, rx);
      send_frame({OP_RD_INV, 24'h0}, FRAME_BITS, rx);
      send_frame({OP_RD_LEDS, 24'h0}, FRAME_BITS, rx);
      send_frame({OP_NOP, 24'h0}, FRAME_BITS, rx);
      check_led_pins();

      waited = 0;
      while (got_q.size() > 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      assert (got_q.size() == 0) else begin
         timeouts++;
         $display("timeout at %0t: replies left unchecked", $time);
      end
      prop_fails = u_spi_probe_top.u_props.fails;
      $display("checks: %0d  mismatches: %0d  timeouts: %0d  assertion failures: %0d",
               checks, errors, timeouts, prop_fails);
      if (errors == 0 && timeouts == 0 && prop_fails == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
hw/spi_probe_pkg.sv
hw/spi_slave.sv
hw/cmd_decoder.sv
hw/sample_capture.sv
hw/sample_ram.sv
hw/spi_probe_top.sv
dv/tb_clkgen.sv
dv/spi_probe_properties.sv
dv/tb_top.sv
